// ==== Bender.yml ====
package:
  name: bus_unit

sources:
  - common/bus_pkg.sv
  - design/bus_arbiter.sv
  - design/store_path.sv
  - clint/clint.sv
  - design/bus_unit.sv
  - target: test
    files:
      - tests/bus_monitor.sv
      - tests/bus_checker.sv
      - tests/tb_bus.sv

// ==== all.f ====
common/bus_pkg.sv
design/bus_arbiter.sv
design/store_path.sv
clint/clint.sv
design/bus_unit.sv
tests/bus_monitor.sv
tests/bus_checker.sv
tests/tb_bus.sv

// ==== clint/clint.sv ====
`timescale 1ns/1ps

module clint (
  input  logic             clock,
  input  logic             reset,
  input  logic             arvalid,
  input  logic             addr_hi,
  output bus_pkg::rd_rsp_t rsp
);
  import bus_pkg::*;

  logic [63:0] mtime;
  xlen_t       rsp_data;
  logic        rsp_valid;

  // free running, one tick per clock
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= 64'd0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= arvalid && !rsp_valid;  // one pulse per request
    end
  end

  // value as of the sampling edge
  always_ff @(posedge clock) begin
    if (arvalid) begin
      rsp_data <= addr_hi ? mtime[63:32] : mtime[31:0];
    end
  end

  assign rsp.data  = rsp_data;
  assign rsp.valid = rsp_valid;

endmodule

// ==== common/bus_pkg.sv ====
package bus_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [7:0] strb_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;

  // AXI size encoding, bytes per beat as a power of two
  localparam size_t size_byte = 3'd0;
  localparam size_t size_half = 3'd1;
  localparam size_t size_word = 3'd2;

  localparam burst_t burst_fixed = 2'b00;
  localparam burst_t burst_incr  = 2'b01;

  // SDRAM window, upper bound exclusive
  localparam xlen_t sdram_lo = 32'ha000_0000;
  localparam xlen_t sdram_hi = 32'hc000_0000;

  typedef struct packed {
    xlen_t addr;
    logic  valid;
    logic  lock;
  } ifu_req_t;

  typedef struct packed {
    xlen_t addr;
    logic  valid;
    strb_t rstrb;
  } lsu_load_t;

  typedef struct packed {
    xlen_t addr;
    logic  awvalid;
    xlen_t data;
    logic  wvalid;
    strb_t wstrb;
  } lsu_store_t;

  typedef struct packed {
    xlen_t data;
    logic  valid;
  } rd_rsp_t;

  typedef struct packed {
    xlen_t      addr;
    logic [7:0] len;
    size_t      size;
    burst_t     burst;
    logic       valid;
  } axi_ar_t;

  typedef struct packed {
    xlen_t data;
    logic  last;
    logic  valid;
  } axi_r_t;

  typedef struct packed {
    xlen_t addr;
    size_t size;
    logic  valid;
  } axi_aw_t;

  typedef struct packed {
    xlen_t      data;
    logic [3:0] strb;
    logic       last;
    logic       valid;
  } axi_w_t;

  typedef struct packed {
    logic valid;
  } axi_b_t;

  // core strobes are 1, 3 or f; anything else falls back to a byte
  function automatic size_t size_from_strb(strb_t strb);
    case (strb)
      8'h01: return size_byte;
      8'h03: return size_half;
      8'h0f: return size_word;
      default: return size_byte;
    endcase
  endfunction

endpackage

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter #(
  parameter bus_pkg::xlen_t clint_base = 32'h0200_bff8,
  parameter bit sdram_burst = 1'b1
) (
  input  logic               clock,
  input  logic               reset,
  input  bus_pkg::ifu_req_t  ifu_req,
  input  logic               ifu_ready,
  input  bus_pkg::lsu_load_t lsu_load,
  input  logic               flush,
  output bus_pkg::axi_ar_t   ar,
  input  logic               ar_ready,
  input  bus_pkg::axi_r_t    r,
  output logic               r_ready,
  output logic               bus_ifu_ready,
  output bus_pkg::rd_rsp_t   ifu_rsp,
  output bus_pkg::rd_rsp_t   lsu_rsp,
  output logic               clint_arvalid,
  output logic               clint_addr_hi,
  input  bus_pkg::rd_rsp_t   clint_rsp
);
  import bus_pkg::*;

  typedef enum logic [2:0] {
    st_fetch_addr,
    st_fetch_data,
    st_load_addr,
    st_load_resp,
    st_load_flushed
  } rd_state_t;

  rd_state_t state;
  logic      is_timer;
  logic      fetch_burst;

  assign is_timer = (lsu_load.addr == clint_base) || (lsu_load.addr == clint_base + 32'd4);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_fetch_addr;
    end else begin
      unique case (state)
        st_fetch_addr: begin
          if (ifu_req.valid && ifu_ready) begin
            if (ar_ready) state <= st_fetch_data;  // hold ar until taken
          end else if (!ifu_req.lock && lsu_load.valid) begin
            state <= st_load_addr;
          end
        end
        st_fetch_data: begin
          if (r.valid && r.last) begin
            state <= st_fetch_addr;
          end
        end
        st_load_addr: begin
          if (ar.valid && ar_ready) begin
            state <= flush ? st_load_flushed : st_load_resp;
          end else if (!ar.valid && (is_timer || ifu_req.valid)) begin
            state <= st_fetch_addr;  // a presented load address stays until taken
          end
        end
        st_load_resp: begin
          if (r.valid) begin
            state <= st_load_addr;
          end else if (flush) begin
            state <= st_load_flushed;
          end
        end
        st_load_flushed: begin
          // swallow the cancelled beat
          if (r.valid) state <= st_load_addr;
        end
        default: state <= st_fetch_addr;
      endcase
    end
  end

  assign bus_ifu_ready = (state == st_fetch_addr);

  assign fetch_burst = sdram_burst && (state == st_fetch_addr) &&
                       (ifu_req.addr >= sdram_lo) && (ifu_req.addr < sdram_hi);

  always_comb begin
    ar.addr  = (state == st_load_addr) ? lsu_load.addr : ifu_req.addr;
    ar.len   = fetch_burst ? 8'd1 : 8'd0;
    ar.burst = fetch_burst ? burst_incr : burst_fixed;
    ar.size  = (state == st_fetch_addr) ? size_word : size_from_strb(lsu_load.rstrb);
    ar.valid = ((state == st_fetch_addr) && ifu_req.valid && ifu_ready) ||
               ((state == st_load_addr) && lsu_load.valid && !is_timer);
  end

  assign r_ready = (state == st_fetch_data) || (state == st_load_resp) ||
                   (state == st_load_flushed);

  // responses go straight through from the r channel
  always_comb begin
    ifu_rsp.data  = r.data;
    ifu_rsp.valid = (state == st_fetch_data) && r.valid;
    lsu_rsp.data  = clint_rsp.valid ? clint_rsp.data : r.data;
    lsu_rsp.valid = ((state == st_load_resp) && r.valid) || clint_rsp.valid;
  end

  // timer loads bypass arbitration
  assign clint_arvalid = lsu_load.valid && is_timer;
  assign clint_addr_hi = (lsu_load.addr == clint_base + 32'd4);

endmodule

// ==== design/bus_unit.sv ====
`timescale 1ns/1ps

module bus_unit #(
  parameter bus_pkg::xlen_t clint_base = 32'h0200_bff8,
  parameter bit sdram_burst = 1'b1
) (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::ifu_req_t   ifu_req,
  input  logic                ifu_ready,
  output logic                bus_ifu_ready,
  input  bus_pkg::lsu_load_t  lsu_load,
  input  bus_pkg::lsu_store_t lsu_store,
  input  logic                flush,
  output bus_pkg::rd_rsp_t    ifu_rsp,
  output bus_pkg::rd_rsp_t    lsu_rsp,
  output logic                lsu_wready,
  output bus_pkg::axi_ar_t    ar,
  input  logic                ar_ready,
  input  bus_pkg::axi_r_t     r,
  output logic                r_ready,
  output bus_pkg::axi_aw_t    aw,
  input  logic                aw_ready,
  output bus_pkg::axi_w_t     w,
  input  logic                w_ready,
  input  bus_pkg::axi_b_t     b,
  output logic                b_ready
);
  import bus_pkg::*;

  logic    clint_arvalid;
  logic    clint_addr_hi;
  rd_rsp_t clint_rsp;

  bus_arbiter #(
    .clint_base (clint_base),
    .sdram_burst(sdram_burst)
  ) u_arbiter (
    .clock        (clock),
    .reset        (reset),
    .ifu_req      (ifu_req),
    .ifu_ready    (ifu_ready),
    .lsu_load     (lsu_load),
    .flush        (flush),
    .ar           (ar),
    .ar_ready     (ar_ready),
    .r            (r),
    .r_ready      (r_ready),
    .bus_ifu_ready(bus_ifu_ready),
    .ifu_rsp      (ifu_rsp),
    .lsu_rsp      (lsu_rsp),
    .clint_arvalid(clint_arvalid),
    .clint_addr_hi(clint_addr_hi),
    .clint_rsp    (clint_rsp)
  );

  // write side runs alongside the read side
  store_path u_store (
    .clock     (clock),
    .reset     (reset),
    .lsu_store (lsu_store),
    .aw        (aw),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_ready   (w_ready),
    .b         (b),
    .b_ready   (b_ready),
    .lsu_wready(lsu_wready)
  );

  clint u_clint (
    .clock  (clock),
    .reset  (reset),
    .arvalid(clint_arvalid),
    .addr_hi(clint_addr_hi),
    .rsp    (clint_rsp)
  );

endmodule

// ==== design/store_path.sv ====
`timescale 1ns/1ps

module store_path (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::lsu_store_t lsu_store,
  output bus_pkg::axi_aw_t    aw,
  input  logic                aw_ready,
  output bus_pkg::axi_w_t     w,
  input  logic                w_ready,
  input  bus_pkg::axi_b_t     b,
  output logic                b_ready,
  output logic                lsu_wready
);
  import bus_pkg::*;

  typedef enum logic [1:0] {
    st_addr,
    st_data,
    st_resp
  } wr_state_t;

  wr_state_t  state;
  logic [1:0] lane;  // byte offset taken at the aw handshake

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_addr;
    end else begin
      unique case (state)
        st_addr: begin
          if (aw.valid && aw_ready) state <= st_data;
        end
        st_data: begin
          if (w.valid && w_ready) state <= st_resp;  // beat accepted
        end
        st_resp: begin
          if (b.valid) state <= st_addr;
        end
        default: state <= st_addr;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (aw.valid && aw_ready) begin
      lane <= lsu_store.addr[1:0];
    end
  end

  always_comb begin
    aw.addr  = lsu_store.addr;
    aw.size  = size_from_strb(lsu_store.wstrb);
    aw.valid = (state == st_addr) && lsu_store.awvalid;
  end

  // move data and strobes onto the addressed byte lanes
  always_comb begin
    w.data  = lsu_store.data << {lane, 3'b000};
    w.strb  = lsu_store.wstrb[3:0] << lane;
    w.valid = (state == st_data) && lsu_store.wvalid;
    w.last  = w.valid && w_ready;  // single beat
  end

  assign b_ready    = (state == st_resp);
  assign lsu_wready = b.valid && b_ready;

endmodule

// ==== tests/bus_checker.sv ====
`timescale 1ns/1ps

module bus_checker #(
  parameter bus_pkg::xlen_t clint_base = 32'h0200_bff8
) (
  input logic              clock,
  input logic              reset,
  input bus_pkg::axi_ar_t  ar,
  input logic              ar_ready,
  input bus_pkg::axi_aw_t  aw,
  input logic              aw_ready,
  input bus_pkg::axi_w_t   w,
  input logic              w_ready,
  input logic              r_ready,
  input logic              bus_ifu_ready
);
  import bus_pkg::*;

  int failures = 0;

  ar_held: assert property (@(posedge clock) disable iff (reset)
    (ar.valid && !ar_ready) |=> ar.valid)
    else begin
      failures++;
      $error("ar valid dropped before ready");
    end

  aw_held: assert property (@(posedge clock) disable iff (reset)
    (aw.valid && !aw_ready) |=> aw.valid)
    else begin
      failures++;
      $error("aw valid dropped before ready");
    end

  w_held: assert property (@(posedge clock) disable iff (reset)
    (w.valid && !w_ready) |=> w.valid)
    else begin
      failures++;
      $error("w valid dropped before ready");
    end

  // bus_ifu_ready marks the fetch address state
  no_r_ready_idle: assert property (@(posedge clock) disable iff (reset)
    !(bus_ifu_ready && r_ready))
    else begin
      failures++;
      $error("r_ready high in fetch address state");
    end

  no_timer_ar: assert property (@(posedge clock) disable iff (reset)
    ar.valid |-> (ar.addr != clint_base && ar.addr != clint_base + 32'd4))
    else begin
      failures++;
      $error("timer address reached the ar channel");
    end

endmodule

bind bus_unit bus_checker #(.clint_base(clint_base)) u_checker (
  .clock(clock), .reset(reset), .ar(ar), .ar_ready(ar_ready), .aw(aw), .aw_ready(aw_ready),
  .w(w), .w_ready(w_ready), .r_ready(r_ready), .bus_ifu_ready(bus_ifu_ready)
);

// ==== tests/bus_monitor.sv ====
`timescale 1ns/1ps

module bus_monitor #(
  parameter bus_pkg::xlen_t clint_base = 32'h0200_bff8
) (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::ifu_req_t   ifu_req,
  input  bus_pkg::lsu_load_t  lsu_load,
  input  bus_pkg::lsu_store_t lsu_store,
  input  logic                bus_ifu_ready,
  input  bus_pkg::rd_rsp_t    ifu_rsp,
  input  bus_pkg::rd_rsp_t    lsu_rsp,
  input  logic                lsu_wready,
  input  bus_pkg::axi_ar_t    ar,
  input  logic                ar_ready,
  input  bus_pkg::axi_aw_t    aw,
  input  logic                aw_ready,
  input  bus_pkg::axi_w_t     w,
  input  logic                w_ready,
  input  bus_pkg::axi_b_t     b,
  output int                  errors
);
  import bus_pkg::*;

  logic [63:0] ticks;  // mirrors the timer
  logic [63:0] exp_ticks;
  xlen_t       fetch_addr;
  xlen_t       load_addr;
  int          beat;
  logic [1:0]  lane;
  logic        in_window;

  function automatic xlen_t mem_hash(xlen_t a);
    return (a ^ 32'h3c6e_f372) * 32'h0100_0193 + {a[15:0], a[31:16]};
  endfunction

  function automatic logic [2:0] strobe_size(logic [7:0] s);
    case (s)
      8'h03: return 3'd1;
      8'h0f: return 3'd2;
      default: return 3'd0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
    end
  endtask

  initial errors = 0;

  always @(posedge clock) begin
    if (reset) ticks <= 64'd0;
    else ticks <= ticks + 64'd1;
  end

  always @(negedge clock) begin
    if (!reset) begin
      if (ar.valid && ar_ready) begin
        if (bus_ifu_ready) begin
          fetch_addr = ifu_req.addr;
          beat = 0;
          in_window = (ifu_req.addr >= 32'ha000_0000) && (ifu_req.addr < 32'hc000_0000);
          compare("ar.addr", ifu_req.addr, ar.addr);
          compare("ar.len", in_window ? 32'd1 : 32'd0, ar.len);
          compare("ar.burst", in_window ? 32'd1 : 32'd0, ar.burst);
          compare("ar.size", 32'd2, ar.size);
        end else begin
          load_addr = lsu_load.addr;
          compare("ar.addr", lsu_load.addr, ar.addr);
          compare("ar.size", strobe_size(lsu_load.rstrb), ar.size);
        end
      end
      if (ifu_rsp.valid) begin
        compare("ifu_rsp.data", mem_hash(fetch_addr + 32'd4 * beat), ifu_rsp.data);
        beat++;
      end
      if (lsu_rsp.valid) begin
        if (lsu_load.valid && (lsu_load.addr == clint_base || lsu_load.addr == clint_base + 4)) begin
          exp_ticks = ticks - 64'd1;  // value at the sampling edge
          compare("lsu_rsp.data",
                  (lsu_load.addr == clint_base + 4) ? exp_ticks[63:32] : exp_ticks[31:0],
                  lsu_rsp.data);
        end else begin
          compare("lsu_rsp.data", mem_hash(load_addr), lsu_rsp.data);
        end
      end
      if (aw.valid && aw_ready) begin
        lane = lsu_store.addr[1:0];
        compare("aw.addr", lsu_store.addr, aw.addr);
        compare("aw.size", strobe_size(lsu_store.wstrb), aw.size);
      end
      if (w.valid && w_ready) begin
        compare("w.data", lsu_store.data << (8 * lane), w.data);
        compare("w.strb", {28'd0, lsu_store.wstrb[3:0] << lane}, w.strb);
        compare("w.last", 32'd1, w.last);
      end
      compare("lsu_wready", b.valid, lsu_wready);
    end
  end

endmodule

// ==== tests/tb_bus.sv ====
`timescale 1ns/1ps

module tb_bus;
  import bus_pkg::*;

  localparam xlen_t clint_base = 32'h0200_bff8;
  localparam int ev_ar = 0;
  localparam int ev_ifu = 1;
  localparam int ev_lsu = 2;
  localparam int ev_aw = 3;
  localparam int ev_w = 4;
  localparam int ev_wready = 5;

  logic       clock;
  logic       reset;
  ifu_req_t   ifu_req;
  logic       ifu_ready;
  logic       bus_ifu_ready;
  lsu_load_t  lsu_load;
  lsu_store_t lsu_store;
  logic       flush;
  rd_rsp_t    ifu_rsp;
  rd_rsp_t    lsu_rsp;
  logic       lsu_wready;
  axi_ar_t    ar;
  logic       ar_ready;
  axi_r_t     r;
  logic       r_ready;
  axi_aw_t    aw;
  logic       aw_ready;
  axi_w_t     w;
  logic       w_ready;
  axi_b_t     b;
  logic       b_ready;
  xlen_t      lcg_state;
  int         fails;
  int         mon_errors;

  bus_unit #(.clint_base(clint_base), .sdram_burst(1'b1)) DUT (.*);

  bus_monitor #(.clint_base(clint_base)) u_monitor (
    .clock(clock), .reset(reset), .ifu_req(ifu_req), .lsu_load(lsu_load),
    .lsu_store(lsu_store), .bus_ifu_ready(bus_ifu_ready), .ifu_rsp(ifu_rsp),
    .lsu_rsp(lsu_rsp), .lsu_wready(lsu_wready), .ar(ar), .ar_ready(ar_ready), .aw(aw),
    .aw_ready(aw_ready), .w(w), .w_ready(w_ready), .b(b), .errors(mon_errors)
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  function automatic xlen_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic xlen_t mem_hash(xlen_t a);
    return (a ^ 32'h3c6e_f372) * 32'h0100_0193 + {a[15:0], a[31:16]};
  endfunction

  function automatic bit seen(int which);
    case (which)
      ev_ar: return ar.valid && ar_ready;
      ev_ifu: return ifu_rsp.valid;
      ev_lsu: return lsu_rsp.valid;
      ev_aw: return aw.valid && aw_ready;
      ev_w: return w.valid && w_ready;
      default: return lsu_wready;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $finish;
  endtask

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  // n counts the extra negedges before the event
  task automatic wait_until(input int which, input string what, output int n);
    n = 0;
    @(negedge clock);
    while (!seen(which)) begin
      n++;
      if (n > 200) abort_run({"timed out waiting for ", what});
      @(negedge clock);
    end
  endtask

  task automatic fetch_instr(input xlen_t addr);
    int n;
    step();
    ifu_req.addr = addr;
    ifu_req.valid = 1'b1;
    wait_until(ev_ar, "fetch address handshake", n);
    step();
    ifu_req.valid = 1'b0;
    repeat ((addr >= 32'ha000_0000 && addr < 32'hc000_0000) ? 2 : 1)
      wait_until(ev_ifu, "fetch data", n);
  endtask

  task automatic load_memory(input xlen_t addr, input strb_t strb);
    int n;
    step();
    lsu_load = '{addr: addr, valid: 1'b1, rstrb: strb};
    wait_until(ev_ar, "load address handshake", n);
    step();
    lsu_load.valid = 1'b0;
    wait_until(ev_lsu, "load response", n);
  endtask

  task automatic read_timer(input bit hi);
    int n;
    step();
    lsu_load = '{addr: clint_base + (hi ? 32'd4 : 32'd0), valid: 1'b1, rstrb: 8'h0f};
    wait_until(ev_lsu, "timer response", n);
    if (n != 1) begin
      fails++;
      $display("timer load answered after %0d cycles instead of one", n);
    end
    step();
    lsu_load.valid = 1'b0;
  endtask

  task automatic store_memory(input xlen_t addr, input xlen_t data, input strb_t strb);
    int n;
    step();
    lsu_store = '{addr: addr, awvalid: 1'b1, data: data, wvalid: 1'b1, wstrb: strb};
    wait_until(ev_aw, "store address handshake", n);
    step();
    lsu_store.awvalid = 1'b0;
    wait_until(ev_w, "store data handshake", n);
    step();
    lsu_store.wvalid = 1'b0;
    wait_until(ev_wready, "store response", n);
  endtask

  task automatic cancel_load(input xlen_t addr, input strb_t strb);
    int n;
    step();
    lsu_load = '{addr: addr, valid: 1'b1, rstrb: strb};
    wait_until(ev_ar, "flushed load address handshake", n);
    step();
    lsu_load.valid = 1'b0;
    flush = 1'b1;
    step();
    flush = 1'b0;
    n = 0;
    do begin
      @(negedge clock);
      if (lsu_rsp.valid) begin
        fails++;
        $display("a flushed load still returned data at %0t", $time);
      end
      n++;
      if (n > 200) abort_run("the cancelled read beat never arrived");
    end while (!(r.valid && r_ready));
  endtask

  task automatic check_lock(input xlen_t addr);
    int n;
    fetch_instr(32'h8000_0100);
    step();
    ifu_req.lock = 1'b1;
    lsu_load = '{addr: addr, valid: 1'b1, rstrb: 8'h0f};
    repeat (6) begin
      @(negedge clock);
      if (ar.valid || !bus_ifu_ready) begin
        fails++;
        $display("load took the bus while the fetch lock was held");
      end
    end
    step();
    ifu_req.lock = 1'b0;
    step();
    ifu_req.addr = 32'h8000_0200;  // fetch raised while the load waits
    ifu_req.valid = 1'b1;
    wait_until(ev_ar, "load address after lock release", n);
    if (bus_ifu_ready) begin
      fails++;
      $display("a later fetch took the bus before the pending load");
    end
    step();
    lsu_load.valid = 1'b0;
    wait_until(ev_lsu, "load response after lock release", n);
    wait_until(ev_ar, "fetch address after the released load", n);
    step();
    ifu_req.valid = 1'b0;
    wait_until(ev_ifu, "fetch data after the released load", n);
  endtask

  function automatic strb_t pick_strb(xlen_t rnd);
    case (rnd % 3)
      0: return 8'h01;
      1: return 8'h03;
      default: return 8'h0f;
    endcase
  endfunction

  function automatic xlen_t pick_addr(xlen_t rnd, strb_t strb);
    logic [1:0] lane;
    lane = (strb == 8'h01) ? rnd[31:30] : (strb == 8'h03) ? {rnd[31], 1'b0} : 2'b00;
    return {8'h81, rnd[23:2], lane};
  endfunction

  always begin : read_slave
    int i;
    int n;
    int beats;
    xlen_t rd_addr;
    xlen_t rnd;
    @(negedge clock);
    if (!reset && ar.valid && ar_ready) begin
      rd_addr = ar.addr;
      beats = ar.len + 1;
      step();
      ar_ready = 1'b0;
      for (i = 0; i < beats; i++) begin
        repeat (1 + next_rand() % 3) step();  // never in the cycle after ar
        r.data = mem_hash(rd_addr + 32'd4 * i);
        r.last = (i == beats - 1);
        r.valid = 1'b1;
        n = 0;
        @(negedge clock);
        while (!r_ready) begin
          n++;
          if (n > 200) abort_run("read data beat was never accepted");
          @(negedge clock);
        end
        step();
        r = '0;
      end
    end else begin
      step();
    end
    rnd = next_rand();
    ar_ready = rnd[7] | rnd[9];
  end

  always begin : write_slave
    int n;
    xlen_t rnd;
    @(negedge clock);
    if (!reset && w.valid && w_ready) begin
      step();
      w_ready = 1'b0;
      repeat (next_rand() % 3) step();
      b.valid = 1'b1;
      n = 0;
      @(negedge clock);
      while (!b_ready) begin
        n++;
        if (n > 200) abort_run("write response was never accepted");
        @(negedge clock);
      end
    end
    step();
    b.valid = 1'b0;
    rnd = next_rand();
    aw_ready = rnd[5] | rnd[11];
    w_ready = rnd[6] | rnd[12];
  end

  initial begin : main
    xlen_t rnd;
    strb_t strb;
    int total;
    lcg_state = 32'h929cc638;
    fails = 0;
    reset = 1'b1;
    ifu_req = '0;
    ifu_ready = 1'b1;
    lsu_load = '0;
    lsu_store = '0;
    flush = 1'b0;
    ar_ready = 1'b0;
    r = '0;
    aw_ready = 1'b0;
    w_ready = 1'b0;
    b = '0;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;

    repeat (80) begin
      rnd = next_rand();
      strb = pick_strb(next_rand());
      case (rnd % 6)
        0: fetch_instr({rnd[3] ? 4'ha : 4'h8, 4'h0, rnd[27:6], 2'b00});
        1: load_memory(pick_addr(next_rand(), strb), strb);
        2: read_timer(rnd[4]);
        3: store_memory(pick_addr(next_rand(), strb), next_rand(), strb);
        4: begin
          cancel_load(pick_addr(next_rand(), strb), strb);
          load_memory(pick_addr(next_rand(), strb), strb);
        end
        default: check_lock(pick_addr(next_rand(), 8'h0f));
      endcase
    end

    repeat (4) step();
    total = fails + mon_errors + DUT.u_checker.failures;
    $display("summary: %0d data errors, %0d sequence errors, %0d assertion failures",
             mon_errors, fails, DUT.u_checker.failures);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
